// ==== Makefile ====
# Verilator build and run of the eightbit testbench

VERILATOR ?= verilator
TOP       ?= tb_eightbit
FILELIST  ?= eightbit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0 -Wno-fatal
PASS_TEXT ?= All tests passed

.DEFAULT_GOAL := help

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bus_pkg.sv ====
`default_nettype none
`include "eightbit_consts.svh"

package bus_pkg;

    typedef logic [`EIGHTBIT_WORD_W-1:0] addr_t;

    // Encoded as {en, ready} of a pipeline stage
    typedef enum logic [1:0] {
        st_idle      = 2'b00,
        st_resetting = 2'b01,
        st_busy      = 2'b10,
        st_complete  = 2'b11
    } stage_state_t;

    typedef enum logic [1:0] {
        own_none,
        own_fetch,
        own_exec
    } bus_owner_t;

endpackage

`default_nettype wire

// ==== decode.sv ====
`default_nettype none

module decode
    import isa_pkg::*;
(
    input  wire        clk,
    input  wire        en,
    input  wire inst_t inst,
    output opcode_t    op,
    output reg_idx_t   reg0,
    output reg_idx_t   reg1,
    output reg_idx_t   reg2,
    output word_t      imm,
    output logic       ready
);

    opcode_t inst_op;
    logic    long_imm;

    assign inst_op  = opcode_t'(inst[15:12]);
    assign long_imm = (inst_op == op_jmp) || (inst_op == op_lodi); // Full low byte

    // Fields are taken only in the first cycle of en, fetch may move on after that
    always_ff @(posedge clk) begin
        if (en && !ready) begin
            op   <= inst_op;
            reg0 <= inst[11:8];
            reg1 <= inst[7:4];
            reg2 <= inst[3:0];
            imm  <= long_imm ? inst[7:0] : word_t'(inst[3:0]);
        end
    end

    always_ff @(posedge clk) begin
        ready <= en;
    end

endmodule

`default_nettype wire

// ==== eightbit.f ====
+incdir+.
isa_pkg.sv
bus_pkg.sv
fetch.sv
decode.sv
exec.sv
register_file.sv
eightbit.sv
tb_eightbit.sv

// ==== eightbit.sv ====
`default_nettype none
`include "eightbit_consts.svh"

module eightbit
    import isa_pkg::*, bus_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        mem_ready,
    inout  wire word_t data,
    output addr_t      addr,
    output logic       we,
    output logic       mem_req
);

    addr_t        pc;
    addr_t        jump_target;
    logic         jump_taken;

    logic         fetch_en;
    logic         fetch_ready;
    logic         fetch_mem_req;
    logic         fetch_mem_ready;
    addr_t        fetch_addr;
    inst_t        fetch_inst;
    stage_state_t fetch_state;

    logic         decode_en;
    logic         decode_ready;
    opcode_t      decode_op;
    reg_idx_t     decode_reg0;
    reg_idx_t     decode_reg1;
    reg_idx_t     decode_reg2;
    word_t        decode_imm;
    stage_state_t decode_state;

    logic         exec_en;
    logic         exec_ready;
    opcode_t      exec_op;
    reg_idx_t     exec_wb_idx;
    word_t        exec_reg0_in;
    word_t        exec_reg1_in;
    word_t        exec_imm_in;
    word_t        exec_val_out;
    addr_t        exec_mem_addr;
    word_t        exec_mem_data_out;
    logic         exec_mem_req;
    logic         exec_mem_we;
    logic         exec_mem_ready;
    stage_state_t exec_state;

    logic         wb_en;
    logic         wb_ready;
    opcode_t      wb_op;
    reg_idx_t     wb_idx;
    stage_state_t wb_state;

    word_t        rd_a;
    word_t        rd_b;
    word_t        rd_c;

    bus_owner_t   owner;
    logic         beat_gap;
    logic         bus_free;
    logic         issue_exec;
    logic         issue_fetch;
    word_t        rd_data;
    word_t        wr_data;

    logic         fetch_start;
    logic         decode_start;
    logic         exec_start;
    logic         wb_start;

    fetch u_fetch (
        .clk(clk), .rst(rst), .en(fetch_en), .pc(pc), .data_in(rd_data),
        .mem_ready(fetch_mem_ready), .addr(fetch_addr), .mem_req(fetch_mem_req),
        .inst_out(fetch_inst), .ready(fetch_ready)
    );

    decode u_decode (
        .clk(clk), .en(decode_en), .inst(fetch_inst), .op(decode_op),
        .reg0(decode_reg0), .reg1(decode_reg1), .reg2(decode_reg2),
        .imm(decode_imm), .ready(decode_ready)
    );

    exec u_exec (
        .clk(clk), .rst(rst), .en(exec_en), .op(exec_op), .reg0(exec_reg0_in),
        .reg1(exec_reg1_in), .imm(exec_imm_in), .mem_data_in(rd_data),
        .mem_ready(exec_mem_ready), .val_out(exec_val_out), .mem_addr(exec_mem_addr),
        .mem_data_out(exec_mem_data_out), .mem_req(exec_mem_req), .mem_we(exec_mem_we),
        .ready(exec_ready)
    );

    register_file u_register_file (
        .clk(clk), .rst(rst), .rd_idx_a(decode_reg0), .rd_idx_b(decode_reg1),
        .rd_idx_c(decode_reg2), .rd_a(rd_a), .rd_b(rd_b), .rd_c(rd_c),
        .wb_en(wb_en), .wb_op(wb_op), .wb_idx(wb_idx), .wb_val(exec_val_out),
        .ready(wb_ready)
    );

    assign fetch_state  = stage_state_t'({fetch_en, fetch_ready});
    assign decode_state = stage_state_t'({decode_en, decode_ready});
    assign exec_state   = stage_state_t'({exec_en, exec_ready});
    assign wb_state     = stage_state_t'({wb_en, wb_ready});

    assign fetch_start  = (fetch_state == st_idle) || (fetch_state == st_resetting);
    assign decode_start = (fetch_state == st_complete) && (decode_state == st_idle);
    // No forwarding, so registers are read only once writeback has gone idle
    assign exec_start   = (decode_state == st_complete) && (wb_state == st_idle) &&
                          ((exec_state == st_idle) || (exec_state == st_resetting));
    assign wb_start     = (exec_state == st_complete) &&
                          ((wb_state == st_idle) || (wb_state == st_resetting));

    assign jump_target = rd_a + decode_imm;
    assign jump_taken  = (decode_op == op_jmp) || (decode_op == op_jeqz && rd_b == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc        <= `EIGHTBIT_RESET_PC;
            fetch_en  <= 1'b0;
            decode_en <= 1'b0;
            exec_en   <= 1'b0;
            wb_en     <= 1'b0;
        end else begin
            if (fetch_start)
                fetch_en <= 1'b1;
            if (decode_start) begin
                decode_en <= 1'b1;
                fetch_en  <= 1'b0;
                pc        <= pc + `EIGHTBIT_PC_STEP;
            end
            if (exec_start) begin
                decode_en <= 1'b0;
                if (jump_taken) begin
                    pc       <= jump_target;
                    fetch_en <= 1'b0; // Wrong-path fetch is abandoned
                end else begin
                    exec_en <= 1'b1;
                end
            end
            if (wb_start) begin
                exec_en <= 1'b0;
                wb_en   <= 1'b1;
            end
            if (wb_state == st_complete)
                wb_en <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_start) begin
            exec_op     <= decode_op;
            exec_wb_idx <= decode_reg0;
            exec_imm_in <= decode_imm;
            if (decode_op == op_str) begin
                exec_reg0_in <= rd_a;
                exec_reg1_in <= rd_b;
            end else begin
                exec_reg0_in <= rd_b;
                exec_reg1_in <= rd_c;
            end
        end
        if (wb_start) begin
            wb_op  <= exec_op;
            wb_idx <= exec_wb_idx;
        end
    end

    // The cycle after a beat is skipped so the owner can see its ready first
    assign bus_free    = !mem_req && !beat_gap;
    assign issue_exec  = bus_free && exec_mem_req &&
                         (owner == own_exec || owner == own_none);
    assign issue_fetch = bus_free && fetch_mem_req &&
                         (owner == own_fetch || (owner == own_none && !exec_mem_req));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            owner           <= own_none;
            mem_req         <= 1'b0;
            we              <= 1'b0;
            beat_gap        <= 1'b0;
            fetch_mem_ready <= 1'b0;
            exec_mem_ready  <= 1'b0;
        end else begin
            fetch_mem_ready <= 1'b0;
            exec_mem_ready  <= 1'b0;
            beat_gap        <= 1'b0;
            if (mem_req && mem_ready) begin
                mem_req         <= 1'b0;
                we              <= 1'b0;
                beat_gap        <= 1'b1;
                fetch_mem_ready <= (owner == own_fetch);
                exec_mem_ready  <= (owner == own_exec);
            end else if (issue_exec) begin
                owner   <= own_exec;
                mem_req <= 1'b1;
                we      <= exec_mem_we;
            end else if (issue_fetch) begin
                owner   <= own_fetch;
                mem_req <= 1'b1;
                we      <= 1'b0;
            end else if (bus_free) begin
                owner <= own_none; // Owner has dropped its request
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_exec) begin
            addr    <= exec_mem_addr;
            wr_data <= exec_mem_data_out;
        end else if (issue_fetch) begin
            addr <= fetch_addr;
        end
        if (mem_req && mem_ready)
            rd_data <= data; // Read data is only valid with the ready pulse
    end

    assign data = we ? wr_data : 'z;

endmodule

`default_nettype wire

// ==== eightbit_consts.svh ====
`ifndef EIGHTBIT_CONSTS_SVH
`define EIGHTBIT_CONSTS_SVH

// Data path and address width
`define EIGHTBIT_WORD_W 8

// One instruction is two bytes in memory
`define EIGHTBIT_INST_W 16

`define EIGHTBIT_NUM_REGS 16

// First instruction is fetched from here
`define EIGHTBIT_RESET_PC 8'h00

// Sequential instructions are two bytes apart
`define EIGHTBIT_PC_STEP 8'd2

`endif

// ==== eightbit_patterns.txt ====
# P <address> <byte> preloads memory, instruction high byte first
# S <address> <byte> is an expected store, in program order
P 00 51 LODI r1, 0x80
P 01 80
P 02 52 LODI r2, 0x05
P 03 05
P 04 53 LODI r3, 0x07
P 05 07
P 06 34 ADD r4, r2, r3 right after r3 is written
P 07 23
P 08 24 STR r4, [r1+0]
P 09 10
P 0a 45 ADDI r5, r4, 3
P 0b 43
P 0c 25 STR r5, [r1+1]
P 0d 11
P 0e 66 NAND r6, r2, r3
P 0f 23
P 10 26 STR r6, [r1+2]
P 11 12
P 12 57 LODI r7, 0x40
P 13 40
P 14 18 LOD r8, [r7+0]
P 15 70
P 16 48 ADDI r8, r8, 2
P 17 82
P 18 28 STR r8, [r1+3]
P 19 13
P 1a 59 LODI r9, 0x20
P 1b 20
P 1c 09 JMP r9 + 2
P 1d 02
P 1e 23 STR r3, [r1+6] is skipped by the JMP
P 1f 16
P 20 22 STR r2, [r1+6] is skipped and later overwritten
P 21 16
P 22 5b LODI r11, 0x26
P 23 26
P 24 7b JEQZ r11, r0, 4 is taken
P 25 04
P 26 23 STR r3, [r1+7] is skipped by the JEQZ
P 27 17
P 28 22 STR r2, [r1+7] is skipped by the JEQZ
P 29 17
P 2a 7b JEQZ r11, r2, 0 is not taken
P 2b 20
P 2c 22 STR r2, [r1+4]
P 2d 14
P 2e 5d LODI r13, 0x9c
P 2f 9c
P 30 2d STR r13, [r9+0] into the skipped code
P 31 90
P 32 1e LOD r14, [r9+0]
P 33 90
P 34 4e ADDI r14, r14, 1
P 35 e1
P 36 2e STR r14, [r1+5]
P 37 15
P 38 00 JMP r0 + 0x38 loops here
P 39 38
P 40 33 data byte for the LOD at 0x14
S 80 0c
S 81 0f
S 82 fa
S 83 35
S 84 05
S 20 9c
S 85 9d

// ==== exec.sv ====
`default_nettype none

module exec
    import isa_pkg::*, bus_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire          en,
    input  wire opcode_t op,
    input  wire word_t   reg0,
    input  wire word_t   reg1,
    input  wire word_t   imm,
    input  wire word_t   mem_data_in,
    input  wire          mem_ready,
    output word_t        val_out,
    output addr_t        mem_addr,
    output word_t        mem_data_out,
    output logic         mem_req,
    output logic         mem_we,
    output logic         ready
);

    typedef enum logic [1:0] {
        x_idle,
        x_mem,
        x_done
    } exec_fsm_t;

    exec_fsm_t state;
    logic      is_mem_op;
    logic      start;

    assign is_mem_op = (op == op_lod) || (op == op_str);
    assign start     = (state == x_idle) && en;

    assign mem_req = (state == x_mem);
    assign mem_we  = mem_req && (op == op_str);
    assign ready   = (state == x_done);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= x_idle;
        end else begin
            case (state)
                x_idle: if (en) state <= is_mem_op ? x_mem : x_done;
                x_mem: if (mem_ready) state <= x_done; // Bus latency varies
                x_done: if (!en) state <= x_idle;
                default: state <= x_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            // STR base register arrives on reg1, for LOD it arrives on reg0
            mem_addr     <= ((op == op_str) ? reg1 : reg0) + imm;
            mem_data_out <= reg0;
            case (op)
                op_add:  val_out <= reg0 + reg1;
                op_addi: val_out <= reg0 + imm;
                op_lodi: val_out <= imm;
                op_nand: val_out <= ~(reg0 & reg1);
                default: val_out <= val_out;
            endcase
        end
        if (state == x_mem && mem_ready && op == op_lod)
            val_out <= mem_data_in;
    end

endmodule

`default_nettype wire

// ==== fetch.sv ====
`default_nettype none

module fetch
    import isa_pkg::*, bus_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        en,
    input  wire addr_t pc,
    input  wire word_t data_in,
    input  wire        mem_ready,
    output addr_t      addr,
    output logic       mem_req,
    output inst_t      inst_out,
    output logic       ready
);

    typedef enum logic [2:0] {
        f_idle,
        f_hi,
        f_lo,
        f_done,
        f_drain
    } fetch_fsm_t;

    fetch_fsm_t state;
    word_t      hi_byte;

    assign mem_req = (state == f_hi) || (state == f_lo) || (state == f_drain);
    assign ready   = (state == f_done);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= f_idle;
        end else begin
            case (state)
                f_idle: if (en) state <= f_hi;
                f_hi: begin
                    if (mem_ready)
                        state <= en ? f_lo : f_idle;
                    else if (!en)
                        state <= f_drain; // A beat may already be on the bus
                end
                f_lo: begin
                    if (mem_ready)
                        state <= en ? f_done : f_idle;
                    else if (!en)
                        state <= f_drain;
                end
                f_done: if (!en) state <= f_idle;
                f_drain: if (mem_ready) state <= f_idle; // Result is thrown away
                default: state <= f_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == f_idle && en)
            addr <= pc;
        if (state == f_hi && mem_ready) begin
            hi_byte <= data_in;
            addr    <= addr + 1'b1; // Low byte follows the high byte
        end
        if (state == f_lo && mem_ready && en)
            inst_out <= {hi_byte, data_in};
    end

endmodule

`default_nettype wire

// ==== isa_pkg.sv ====
`default_nettype none
`include "eightbit_consts.svh"

package isa_pkg;

    typedef logic [`EIGHTBIT_WORD_W-1:0] word_t;

    typedef logic [`EIGHTBIT_INST_W-1:0] inst_t;

    typedef logic [$clog2(`EIGHTBIT_NUM_REGS)-1:0] reg_idx_t;

    // Values 8 to 15 are decoded but behave as no-ops
    typedef enum logic [3:0] {
        op_jmp  = 4'd0,
        op_lod  = 4'd1,
        op_str  = 4'd2,
        op_add  = 4'd3,
        op_addi = 4'd4,
        op_lodi = 4'd5,
        op_nand = 4'd6,
        op_jeqz = 4'd7
    } opcode_t;

endpackage

`default_nettype wire

// ==== register_file.sv ====
`default_nettype none
`include "eightbit_consts.svh"

module register_file
    import isa_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire reg_idx_t rd_idx_a,
    input  wire reg_idx_t rd_idx_b,
    input  wire reg_idx_t rd_idx_c,
    output word_t         rd_a,
    output word_t         rd_b,
    output word_t         rd_c,
    input  wire           wb_en,
    input  wire opcode_t  wb_op,
    input  wire reg_idx_t wb_idx,
    input  wire word_t    wb_val,
    output logic          ready
);

    word_t regs [`EIGHTBIT_NUM_REGS];
    logic  has_result;

    always_comb begin
        case (wb_op)
            op_lod, op_add, op_addi, op_lodi, op_nand: has_result = 1'b1;
            default: has_result = 1'b0; // Jumps, stores and no-ops write nothing
        endcase
    end

    assign rd_a = regs[rd_idx_a];
    assign rd_b = regs[rd_idx_b];
    assign rd_c = regs[rd_idx_c];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `EIGHTBIT_NUM_REGS; i++)
                regs[i] <= '0;
            ready <= 1'b0;
        end else begin
            ready <= wb_en;
            if (wb_en && !ready && has_result)
                regs[wb_idx] <= wb_val; // One write per enable
        end
    end

endmodule

`default_nettype wire

// ==== tb_eightbit.sv ====
`default_nettype none

module tb_eightbit;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int MEM_SIZE    = 256;

    logic       clk;
    logic       rst;
    logic       mem_ready;
    wire  [7:0] data;
    logic [7:0] addr;
    logic       we;
    logic       mem_req;

    logic [7:0] mem [MEM_SIZE];
    logic [7:0] exp_addr [$];
    logic [7:0] exp_val [$];
    int         num_stores;
    int         stores_seen;
    bit         loaded;
    integer     seed;

    logic       drive_en;
    logic [7:0] rd_byte;
    bit         busy;
    bit         first_seen;
    int         wait_left;

    assign data = drive_en ? rd_byte : 8'bz; // Memory drives only during a read ready pulse

    eightbit UUT (
        .clk(clk),
        .rst(rst),
        .mem_ready(mem_ready),
        .data(data),
        .addr(addr),
        .we(we),
        .mem_req(mem_req)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] expected);
        if (got !== expected) begin
            $display("Error: %s is 0x%02h, expected 0x%02h", name, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic load_patterns();
        int         fd;
        int         fields;
        string      line;
        logic [7:0] tag;
        logic [7:0] a;
        logic [7:0] v;
        for (int i = 0; i < MEM_SIZE; i++)
            mem[i] = i[7:0] ^ 8'h5a; // Unloaded bytes differ from their neighbours
        fd = $fopen("eightbit_patterns.txt", "r");
        if (fd == 0) begin
            $display("The pattern file eightbit_patterns.txt could not be opened");
            stop_with_failure();
        end else begin
            while ($fgets(line, fd) > 0) begin
                fields = $sscanf(line, "%c %h %h", tag, a, v);
                if (fields == 3 && tag == "P") begin
                    mem[a] = v;
                end else if (fields == 3 && tag == "S") begin
                    exp_addr.push_back(a);
                    exp_val.push_back(v);
                end
            end
            $fclose(fd);
            num_stores = exp_addr.size();
            if (num_stores == 0) begin
                $display("The pattern file holds no expected stores");
                stop_with_failure();
            end
        end
    endtask

    task automatic record_store(input logic [7:0] a, input logic [7:0] v);
        if (stores_seen >= num_stores) begin
            $display("A store to address 0x%02h came after all expected stores", a);
            stop_with_failure();
        end else begin
            check_value("addr", a, exp_addr[stores_seen]);
            check_value("data", v, exp_val[stores_seen]);
            stores_seen++;
        end
    endtask

    // The memory model takes its inputs at the edge and changes its outputs shortly after it
    always @(posedge clk) begin
        logic       cur_rst;
        logic       cur_req;
        logic       cur_we;
        logic       cur_ready;
        logic [7:0] cur_addr;
        logic [7:0] cur_data;
        cur_rst   = rst;
        cur_req   = mem_req;
        cur_we    = we;
        cur_ready = mem_ready;
        cur_addr  = addr;
        cur_data  = data;
        #(DRIVE_DELAY);
        if (cur_rst) begin
            mem_ready = 1'b0;
            drive_en  = 1'b0;
            busy      = 1'b0;
        end else if (cur_ready) begin
            mem_ready = 1'b0; // Ready is a single-cycle pulse
            drive_en  = 1'b0;
            busy      = 1'b0;
        end else if (cur_req) begin
            if (!busy) begin
                busy      = 1'b1;
                wait_left = 1 + ($unsigned($random(seed)) % 3);
                if (!first_seen) begin
                    check_value("addr", cur_addr, 8'h00);
                    check_value("we", 8'(cur_we), 8'h00);
                    first_seen = 1'b1;
                end
            end
            wait_left--;
            if (wait_left == 0) begin
                if (cur_we) begin
                    mem[cur_addr] = cur_data;
                    record_store(cur_addr, cur_data);
                end else begin
                    rd_byte  = mem[cur_addr];
                    drive_en = 1'b1;
                end
                mem_ready = 1'b1;
            end
        end
    end

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        mem_ready   = 1'b0;
        drive_en    = 1'b0;
        rd_byte     = 8'h00;
        busy        = 1'b0;
        first_seen  = 1'b0;
        wait_left   = 0;
        stores_seen = 0;
        num_stores  = 0;
        loaded      = 1'b0;
        seed        = 34;
        load_patterns();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        check_value("mem_req", 8'(mem_req), 8'h00);
        check_value("we", 8'(we), 8'h00);
        wait (stores_seen == num_stores);
        repeat (40) @(posedge clk); // A stray store from a skipped path would land here
        $display("All tests passed");
        $finish;
    end

    // Each store gets 60 cycles, plus a margin for reset and the final loop
    initial begin
        wait (loaded);
        repeat (60 * num_stores + 200) @(posedge clk);
        $display("Timeout: the expected stores did not arrive in time");
        stop_with_failure();
    end

endmodule

`default_nettype wire
